//--- logic/alu_defs.svh
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// Operand and result width
`define ALU_XLEN 64

// Width of one polar lane
`define ALU_LANE_W 8

// Lanes per word, ALU_LANES * ALU_LANE_W == ALU_XLEN
`define ALU_LANES 8

// Clamp magnitude for saturating lane add and subtract
`define ALU_SAT_MAX 127

`endif

//--- logic/alu_pkg.sv
package alu_pkg;

    // Opcodes presented at the ALU input
    typedef enum logic [4:0] {
        PL_R, PL_F, PL_ADDSAT, PL_SUBSAT, PL_DECODE, PL_EVAL,
        OP_ADD, OP_SUB,
        OP_AND, OP_OR, OP_XOR,
        OP_SLTS, OP_SLTU,
        OP_EQ, OP_NE, OP_LTS, OP_LTU, OP_GES, OP_GEU
    } alu_op_e;

    // Function applied by every polar lane
    typedef enum logic [2:0] {
        LN_R, LN_F, LN_ADDSAT, LN_SUBSAT, LN_DECODE, LN_EVAL
    } lane_fn_e;

    // Function of the 64-bit integer unit
    typedef enum logic [3:0] {
        IF_ADD, IF_SUB,
        IF_AND, IF_OR, IF_XOR,
        IF_SLTS, IF_SLTU,
        IF_EQ, IF_NE, IF_LTS, IF_LTU, IF_GES, IF_GEU
    } int_fn_e;

    // Which unit feeds the result register
    typedef enum logic {
        SRC_POLAR, SRC_INT
    } res_src_e;

endpackage

//--- logic/alu_op_decode.sv
`timescale 1ns/10ps
`include "alu_defs.svh"

module alu_op_decode import alu_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 valid_i,
    input  alu_op_e              op_i,
    input  logic [`ALU_XLEN-1:0] operand_a_i,
    input  logic [`ALU_XLEN-1:0] operand_b_i,
    output logic                 valid_o,
    output logic [`ALU_XLEN-1:0] a_o,
    output logic [`ALU_XLEN-1:0] b_o,
    output lane_fn_e             lane_fn_o,
    output int_fn_e              int_fn_o,
    output res_src_e             src_o
);

    lane_fn_e lane_fn_d;
    int_fn_e  int_fn_d;
    res_src_e src_d;

    // ----------------------------
    // Opcode decode
    // ----------------------------
    // Polar ops park the integer unit on a non-branch function so its
    // branch flag reads 1 for them
    always_comb begin
        lane_fn_d = LN_R;
        int_fn_d  = IF_ADD;
        src_d     = SRC_INT;
        case (op_i)
            PL_R:      begin lane_fn_d = LN_R;      src_d = SRC_POLAR; end
            PL_F:      begin lane_fn_d = LN_F;      src_d = SRC_POLAR; end
            PL_ADDSAT: begin lane_fn_d = LN_ADDSAT; src_d = SRC_POLAR; end
            PL_SUBSAT: begin lane_fn_d = LN_SUBSAT; src_d = SRC_POLAR; end
            PL_DECODE: begin lane_fn_d = LN_DECODE; src_d = SRC_POLAR; end
            PL_EVAL:   begin lane_fn_d = LN_EVAL;   src_d = SRC_POLAR; end
            OP_ADD:    int_fn_d = IF_ADD;
            OP_SUB:    int_fn_d = IF_SUB;
            OP_AND:    int_fn_d = IF_AND;
            OP_OR:     int_fn_d = IF_OR;
            OP_XOR:    int_fn_d = IF_XOR;
            OP_SLTS:   int_fn_d = IF_SLTS;
            OP_SLTU:   int_fn_d = IF_SLTU;
            OP_EQ:     int_fn_d = IF_EQ;
            OP_NE:     int_fn_d = IF_NE;
            OP_LTS:    int_fn_d = IF_LTS;
            OP_LTU:    int_fn_d = IF_LTU;
            OP_GES:    int_fn_d = IF_GES;
            OP_GEU:    int_fn_d = IF_GEU;
            default:   int_fn_d = IF_ADD;
        endcase
    end

    // ----------------------------
    // Stage 1 registers
    // ----------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o   <= 1'b0;
            lane_fn_o <= LN_R;
            int_fn_o  <= IF_ADD;
            src_o     <= SRC_POLAR;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                lane_fn_o <= lane_fn_d;
                int_fn_o  <= int_fn_d;
                src_o     <= src_d;
            end
        end
    end

    // Operands only move on a strobe
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            a_o <= operand_a_i;
            b_o <= operand_b_i;
        end
    end

    // Every strobe carries a defined opcode
    op_legal_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i |-> (!$isunknown(op_i) && (op_i inside {[PL_R:OP_GEU]})));

endmodule

//--- logic/polar_lane.sv
`timescale 1ns/10ps
`include "alu_defs.svh"

module polar_lane import alu_pkg::*; (
    input  lane_fn_e                lane_fn_i,
    input  logic [`ALU_LANE_W-1:0]  a_i,
    input  logic [`ALU_LANE_W-1:0]  b_i,
    output logic [`ALU_LANE_W-1:0]  res_o
);

    localparam int unsigned W = `ALU_LANE_W;

    // Clamp limits in the 9-bit domain
    localparam logic signed [W:0] SAT_HI = (W+1)'(`ALU_SAT_MAX);
    localparam logic signed [W:0] SAT_LO = -SAT_HI;

    logic                a_neg;
    logic                b_neg;
    logic [W-1:0]        mag_a;
    logic [W-1:0]        mag_b;
    logic [W-1:0]        min_mag;
    logic signed [W:0]   sum;
    logic signed [W:0]   diff;
    logic [W-1:0]        fn_r;
    logic [W-1:0]        fn_f;
    logic [W-1:0]        fn_decode;
    logic [W-1:0]        fn_eval;

    function automatic logic [W-1:0] sat_clamp(input logic signed [W:0] val);
        logic [W-1:0] res;
        if (val > SAT_HI)
            res = SAT_HI[W-1:0];
        else if (val < SAT_LO)
            res = SAT_LO[W-1:0];
        else
            res = val[W-1:0];
        return res;
    endfunction

    assign a_neg = a_i[W-1];
    assign b_neg = b_i[W-1];

    // Unsigned magnitude, so -128 comes out as 128
    assign mag_a = a_neg ? (~a_i + 1'b1) : a_i;
    assign mag_b = b_neg ? (~b_i + 1'b1) : b_i;

    // ----------------------------
    // Lane functions
    // ----------------------------
    assign fn_r = {{(W-1){1'b0}}, a_neg & (b_i != W'(1))};

    // a wins ties
    assign min_mag = (mag_a <= mag_b) ? mag_a : mag_b;
    assign fn_f    = (a_neg ^ b_neg) ? (~min_mag + 1'b1) : min_mag;

    // Sign-extended to 9 bits before the clamp
    assign sum  = {a_i[W-1], a_i} + {b_i[W-1], b_i};
    assign diff = {a_i[W-1], a_i} - {b_i[W-1], b_i};

    assign fn_decode = (b_i == '0) ? a_i : '0;
    assign fn_eval   = (a_i == W'(1)) ? '1 : '0;

    always_comb begin
        case (lane_fn_i)
            LN_R:      res_o = fn_r;
            LN_F:      res_o = fn_f;
            LN_ADDSAT: res_o = sat_clamp(sum);
            LN_SUBSAT: res_o = sat_clamp(diff);
            LN_DECODE: res_o = fn_decode;
            LN_EVAL:   res_o = fn_eval;
            default:   res_o = '0;
        endcase
    end

endmodule

//--- logic/int_unit.sv
`timescale 1ns/10ps
`include "alu_defs.svh"

module int_unit import alu_pkg::*; (
    input  int_fn_e              int_fn_i,
    input  logic [`ALU_XLEN-1:0] a_i,
    input  logic [`ALU_XLEN-1:0] b_i,
    output logic [`ALU_XLEN-1:0] res_o,
    output logic                 branch_o
);

    localparam int unsigned XLEN = `ALU_XLEN;

    logic                    b_negate;
    logic [XLEN-1:0]         b_op;
    logic [XLEN-1:0]         adder_res;
    logic                    zero_flag;
    logic                    is_signed;
    logic signed [XLEN:0]    a_ext;
    logic signed [XLEN:0]    b_ext;
    logic                    less;

    // ----------------------------
    // Shared adder
    // ----------------------------
    // Subtract and equality both run a - b through the same adder
    assign b_negate = (int_fn_i == IF_SUB) || (int_fn_i == IF_EQ) || (int_fn_i == IF_NE);

    assign b_op      = b_i ^ {XLEN{b_negate}};
    assign adder_res = a_i + b_op + {{(XLEN-1){1'b0}}, b_negate};
    assign zero_flag = ~|adder_res;

    // ----------------------------
    // Less-than comparator
    // ----------------------------
    assign is_signed = (int_fn_i == IF_SLTS) || (int_fn_i == IF_LTS) || (int_fn_i == IF_GES);

    // One extra bit turns the compare signed or unsigned
    assign a_ext = {is_signed & a_i[XLEN-1], a_i};
    assign b_ext = {is_signed & b_i[XLEN-1], b_i};
    assign less  = a_ext < b_ext;

    // Result word, zero for the branch functions
    always_comb begin
        case (int_fn_i)
            IF_ADD, IF_SUB:   res_o = adder_res;
            IF_AND:           res_o = a_i & b_i;
            IF_OR:            res_o = a_i | b_i;
            IF_XOR:           res_o = a_i ^ b_i;
            IF_SLTS, IF_SLTU: res_o = {{(XLEN-1){1'b0}}, less};
            default:          res_o = '0;
        endcase
    end

    // Branch resolution, 1 when the function is not a branch
    always_comb begin
        case (int_fn_i)
            IF_EQ:          branch_o = zero_flag;
            IF_NE:          branch_o = ~zero_flag;
            IF_LTS, IF_LTU: branch_o = less;
            IF_GES, IF_GEU: branch_o = ~less;
            default:        branch_o = 1'b1;
        endcase
    end

endmodule

//--- logic/result_select.sv
`timescale 1ns/10ps
`include "alu_defs.svh"

module result_select import alu_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 valid_i,
    input  res_src_e             src_i,
    input  logic [`ALU_XLEN-1:0] polar_i,
    input  logic [`ALU_XLEN-1:0] int_res_i,
    input  logic                 int_branch_i,
    output logic                 valid_o,
    output logic [`ALU_XLEN-1:0] result_o,
    output logic                 branch_o
);

    logic [`ALU_XLEN-1:0] result_d;

    // Pick the unit that owns this op
    assign result_d = (src_i == SRC_INT) ? int_res_i : polar_i;

    // ----------------------------
    // Output registers
    // ----------------------------
    // Result and flag hold between strobes
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o  <= 1'b0;
            result_o <= '0;
            branch_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                result_o <= result_d;
                branch_o <= int_branch_i;
            end
        end
    end

    // One valid_o per stage-1 valid, exactly a cycle later
    valid_follow_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        1'b1 |=> (valid_o == $past(valid_i)));

    // Decode parks the integer unit on a non-branch function for polar ops
    polar_branch_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (valid_i && (src_i == SRC_POLAR)) |-> int_branch_i);

endmodule

//--- logic/alu_top.sv
`timescale 1ns/10ps
`include "alu_defs.svh"

module alu_top import alu_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 valid_i,
    input  alu_op_e              op_i,
    input  logic [`ALU_XLEN-1:0] operand_a_i,
    input  logic [`ALU_XLEN-1:0] operand_b_i,
    output logic                 valid_o,
    output logic [`ALU_XLEN-1:0] result_o,
    output logic                 branch_o
);

    logic                 dec_valid;
    logic [`ALU_XLEN-1:0] dec_a;
    logic [`ALU_XLEN-1:0] dec_b;
    lane_fn_e             dec_lane_fn;
    int_fn_e              dec_int_fn;
    res_src_e             dec_src;
    logic [`ALU_XLEN-1:0] polar_word;
    logic [`ALU_XLEN-1:0] int_res;
    logic                 int_branch;

    // Stage 1
    alu_op_decode u_alu_op_decode (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .valid_i     (valid_i),
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .valid_o     (dec_valid),
        .a_o         (dec_a),
        .b_o         (dec_b),
        .lane_fn_o   (dec_lane_fn),
        .int_fn_o    (dec_int_fn),
        .src_o       (dec_src)
    );

    // ----------------------------
    // Polar lanes, one per byte
    // ----------------------------
    for (genvar i = 0; i < `ALU_LANES; i++) begin : g_lane
        polar_lane u_polar_lane (
            .lane_fn_i (dec_lane_fn),
            .a_i       (dec_a[i*`ALU_LANE_W +: `ALU_LANE_W]),
            .b_i       (dec_b[i*`ALU_LANE_W +: `ALU_LANE_W]),
            .res_o     (polar_word[i*`ALU_LANE_W +: `ALU_LANE_W])
        );
    end

    int_unit u_int_unit (
        .int_fn_i (dec_int_fn),
        .a_i      (dec_a),
        .b_i      (dec_b),
        .res_o    (int_res),
        .branch_o (int_branch)
    );

    // Stage 2
    result_select u_result_select (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .valid_i      (dec_valid),
        .src_i        (dec_src),
        .polar_i      (polar_word),
        .int_res_i    (int_res),
        .int_branch_i (int_branch),
        .valid_o      (valid_o),
        .result_o     (result_o),
        .branch_o     (branch_o)
    );

endmodule

//--- dv/alu_ref.svh
`ifndef ALU_REF_SVH
`define ALU_REF_SVH

`include "alu_defs.svh"

// Clamp a lane sum into the symmetric saturation range
function automatic int sat_limit(input int v);
    if (v > `ALU_SAT_MAX)
        return `ALU_SAT_MAX;
    if (v < -`ALU_SAT_MAX)
        return -`ALU_SAT_MAX;
    return v;
endfunction

// One signed lane of a polar op
function automatic logic [`ALU_LANE_W-1:0] lane_value(input alu_op_e op,
        input logic [`ALU_LANE_W-1:0] a, input logic [`ALU_LANE_W-1:0] b);
    int sa;
    int sb;
    int ma;
    int mb;
    int v;
    sa = $signed(a);
    sb = $signed(b);
    // -128 keeps magnitude 128
    ma = (sa < 0) ? -sa : sa;
    mb = (sb < 0) ? -sb : sb;
    v  = 0;
    case (op)
        PL_R:      v = (sb == 1) ? 0 : ((sa < 0) ? 1 : 0);
        PL_F: begin
            v = (ma <= mb) ? ma : mb;
            if ((sa < 0) != (sb < 0))
                v = -v;
        end
        PL_ADDSAT: v = sat_limit(sa + sb);
        PL_SUBSAT: v = sat_limit(sa - sb);
        PL_DECODE: v = (sb == 0) ? sa : 0;
        PL_EVAL:   v = (sa == 1) ? -1 : 0;
        default:   v = 0;
    endcase
    return v[`ALU_LANE_W-1:0];
endfunction

// Full result word for any opcode
function automatic logic [`ALU_XLEN-1:0] word_result(input alu_op_e op,
        input logic [`ALU_XLEN-1:0] a, input logic [`ALU_XLEN-1:0] b);
    logic [`ALU_XLEN-1:0] r;
    r = '0;
    case (op)
        PL_R, PL_F, PL_ADDSAT, PL_SUBSAT, PL_DECODE, PL_EVAL: begin
            for (int i = 0; i < `ALU_LANES; i++)
                r[i*`ALU_LANE_W +: `ALU_LANE_W] = lane_value(op,
                    a[i*`ALU_LANE_W +: `ALU_LANE_W], b[i*`ALU_LANE_W +: `ALU_LANE_W]);
        end
        OP_ADD:  r = a + b;
        OP_SUB:  r = a - b;
        OP_AND:  r = a & b;
        OP_OR:   r = a | b;
        OP_XOR:  r = a ^ b;
        OP_SLTS: r = ($signed(a) < $signed(b)) ? `ALU_XLEN'(1) : '0;
        OP_SLTU: r = (a < b) ? `ALU_XLEN'(1) : '0;
        // Branches leave the word at zero
        default: r = '0;
    endcase
    return r;
endfunction

function automatic logic branch_flag(input alu_op_e op,
        input logic [`ALU_XLEN-1:0] a, input logic [`ALU_XLEN-1:0] b);
    case (op)
        OP_EQ:   return a == b;
        OP_NE:   return a != b;
        OP_LTS:  return $signed(a) < $signed(b);
        OP_LTU:  return a < b;
        OP_GES:  return $signed(a) >= $signed(b);
        OP_GEU:  return a >= b;
        default: return 1'b1;
    endcase
endfunction

`endif

//--- dv/alu_tb.sv
`timescale 1ns/10ps
`include "alu_defs.svh"

module alu_tb import alu_pkg::*; ();

    logic                 clk;
    logic                 rst_n;
    logic                 valid;
    alu_op_e              op;
    logic [`ALU_XLEN-1:0] operand_a;
    logic [`ALU_XLEN-1:0] operand_b;
    logic                 valid_o;
    logic [`ALU_XLEN-1:0] result_o;
    logic                 branch_o;

    `include "alu_ref.svh"

    // Stimulus table with expected values
    string                name_q[$];
    alu_op_e              op_q[$];
    logic [`ALU_XLEN-1:0] a_q[$];
    logic [`ALU_XLEN-1:0] b_q[$];
    logic [`ALU_XLEN-1:0] res_q[$];
    logic                 br_q[$];
    int                   n_directed;
    bit                   table_ready = 1'b0;

    // Operations in flight
    string                sb_name[$];
    logic [`ALU_XLEN-1:0] sb_res[$];
    logic                 sb_br[$];
    int unsigned          sb_cycle[$];

    int unsigned          cycle = 0;
    int                   mismatch_count = 0;
    int                   other_errors = 0;
    logic [31:0]          rng_state = 32'hb901;

    alu_top u_alu_top (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .valid_i     (valid),
        .op_i        (op),
        .operand_a_i (operand_a),
        .operand_b_i (operand_b),
        .valid_o     (valid_o),
        .result_o    (result_o),
        .branch_o    (branch_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_entry(input string name, input alu_op_e o,
            input logic [`ALU_XLEN-1:0] a, input logic [`ALU_XLEN-1:0] b);
        name_q.push_back(name);
        op_q.push_back(o);
        a_q.push_back(a);
        b_q.push_back(b);
        res_q.push_back(word_result(o, a, b));
        br_q.push_back(branch_flag(o, a, b));
    endtask

    task automatic random_entries(input int count);
        alu_op_e              o;
        logic [`ALU_XLEN-1:0] a;
        logic [`ALU_XLEN-1:0] b;
        for (int i = 0; i < count; i++) begin
            rng_state = lcg_next(rng_state);
            o = alu_op_e'(rng_state[23:16] % (int'(OP_GEU) + 1));
            rng_state = lcg_next(rng_state);
            a[63:32] = rng_state;
            rng_state = lcg_next(rng_state);
            a[31:0] = rng_state;
            rng_state = lcg_next(rng_state);
            b[63:32] = rng_state;
            rng_state = lcg_next(rng_state);
            b[31:0] = rng_state;
            // Some equal pairs so eq and ne both get hit
            if (rng_state[27:25] == 3'd0)
                b = a;
            add_entry($sformatf("rand_%0d", i), o, a, b);
        end
    endtask

    task automatic apply_entry(input int i);
        @(posedge clk);
        #1;
        valid     = 1'b1;
        op        = op_q[i];
        operand_a = a_q[i];
        operand_b = b_q[i];
        sb_name.push_back(name_q[i]);
        sb_res.push_back(res_q[i]);
        sb_br.push_back(br_q[i]);
        sb_cycle.push_back(cycle);
    endtask

    task automatic expect_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            assert (valid_o === 1'b0 && branch_o === 1'b0 && result_o === '0) else begin
                $display("MISMATCH after_reset expected v=0 b=0 r=0 actual v=%b b=%b r=%h",
                         valid_o, branch_o, result_o);
                mismatch_count++;
            end
        end
    endtask

    task automatic compare_output();
        string                name;
        logic [`ALU_XLEN-1:0] exp_res;
        logic                 exp_br;
        int unsigned          sent;
        assert (sb_name.size() != 0) else begin
            $display("ERROR: valid_o high at cycle %0d with no operation outstanding", cycle);
            other_errors++;
        end
        if (sb_name.size() != 0) begin
            name    = sb_name.pop_front();
            exp_res = sb_res.pop_front();
            exp_br  = sb_br.pop_front();
            sent    = sb_cycle.pop_front();
            assert (cycle - sent == 2) else begin
                $display("ERROR: %s came out %0d cycles after its strobe instead of 2",
                         name, cycle - sent);
                other_errors++;
            end
            assert (result_o === exp_res) else begin
                $display("MISMATCH %s result expected %h actual %h", name, exp_res, result_o);
                mismatch_count++;
            end
            assert (branch_o === exp_br) else begin
                $display("MISMATCH %s branch expected %b actual %b", name, exp_br, branch_o);
                mismatch_count++;
            end
        end
    endtask

    // Outputs settle after the rising edge, so look at the falling one
    always @(negedge clk) begin
        if (rst_n === 1'b1 && valid_o === 1'b1)
            compare_output();
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        valid     = 1'b0;
        op        = PL_R;
        operand_a = '0;
        operand_b = '0;
        rst_n     = 1'b0;

        // name, opcode, operand a, operand b
        add_entry("addsat_clamp", PL_ADDSAT, 64'h649C_8080_057F_0081, 64'h649C_8001_FB01_00FF);
        add_entry("subsat_clamp", PL_SUBSAT, 64'h649C_8000_7F05_8001, 64'h9C64_0180_8105_7FFF);
        add_entry("r_lanes",      PL_R,      64'h80FF_0100_807F_C081, 64'h0100_0101_0500_0180);
        add_entry("f_ties_signs", PL_F,      64'h05FB_0580_8000_03FD, 64'hFB05_0580_7F09_8002);
        add_entry("f_minus128",   PL_F,      64'h8080_7F01_0000_8181, 64'h8001_8080_0080_7F81);
        add_entry("decode_b0",    PL_DECODE, 64'h807F_1234_FF01_00AB, 64'h0001_0080_00FF_0001);
        add_entry("eval_one",     PL_EVAL,   64'h0100_FF01_807F_0201, 64'h1234_5678_9ABC_DEF0);
        add_entry("add_wrap",     OP_ADD,    64'hFFFF_FFFF_FFFF_FFFF, 64'h0000_0000_0000_0001);
        add_entry("add_plain",    OP_ADD,    64'h0123_4567_89AB_CDEF, 64'h1111_2222_3333_4444);
        add_entry("sub_wrap",     OP_SUB,    64'h0000_0000_0000_0000, 64'h0000_0000_0000_0001);
        add_entry("and_op",       OP_AND,    64'hF0F0_FF00_1234_5678, 64'h0FF0_F0F0_FFFF_0000);
        add_entry("or_op",        OP_OR,     64'hF0F0_FF00_1234_5678, 64'h0FF0_F0F0_FFFF_0000);
        add_entry("xor_op",       OP_XOR,    64'hF0F0_FF00_1234_5678, 64'h0FF0_F0F0_FFFF_0000);
        add_entry("slts_top",     OP_SLTS,   64'h8000_0000_0000_0000, 64'h0000_0000_0000_0001);
        add_entry("sltu_top",     OP_SLTU,   64'h8000_0000_0000_0000, 64'h0000_0000_0000_0001);
        add_entry("slts_equal",   OP_SLTS,   64'h0000_0000_0000_0007, 64'h0000_0000_0000_0007);
        add_entry("eq_true",      OP_EQ,     64'hDEAD_BEEF_0000_0001, 64'hDEAD_BEEF_0000_0001);
        add_entry("eq_false",     OP_EQ,     64'hDEAD_BEEF_0000_0001, 64'hDEAD_BEEF_0000_0002);
        add_entry("ne_true",      OP_NE,     64'h0000_0000_0000_0000, 64'h8000_0000_0000_0000);
        add_entry("lts_top",      OP_LTS,    64'hFFFF_FFFF_FFFF_FFFE, 64'h0000_0000_0000_0003);
        add_entry("ltu_top",      OP_LTU,    64'hFFFF_FFFF_FFFF_FFFE, 64'h0000_0000_0000_0003);
        add_entry("ges_top",      OP_GES,    64'hFFFF_FFFF_FFFF_FFFE, 64'h0000_0000_0000_0003);
        add_entry("geu_top",      OP_GEU,    64'hFFFF_FFFF_FFFF_FFFE, 64'h0000_0000_0000_0003);
        add_entry("ges_equal",    OP_GES,    64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000);
        add_entry("geu_equal",    OP_GEU,    64'h0000_0000_0000_0042, 64'h0000_0000_0000_0042);
        n_directed = name_q.size();
        random_entries(200);
        table_ready = 1'b1;

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        expect_idle(3);

        foreach (name_q[i]) begin
            // Short gap between directed and random entries
            if (i == n_directed) begin
                @(posedge clk);
                #1;
                valid = 1'b0;
                @(posedge clk);
            end
            apply_entry(i);
        end
        @(posedge clk);
        #1;
        valid = 1'b0;

        // Last results are due two cycles after the final strobe
        for (int k = 0; k < 8 && sb_name.size() != 0; k++)
            @(negedge clk);
        repeat (3) @(negedge clk);

        assert (sb_name.size() == 0) else begin
            $display("ERROR: %0d results never came out", sb_name.size());
            other_errors++;
        end
        $display("Errors: %0d mismatches, %0d other", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // Budget covers reset, idle checks, gaps and the pipeline drain
    initial begin
        wait (table_ready);
        repeat (name_q.size() + 40) @(posedge clk);
        $display("ERROR: watchdog expired with %0d results still outstanding", sb_name.size());
        $display("Errors: %0d mismatches, %0d other", mismatch_count, other_errors + 1);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- alu_top.f
+incdir+logic
+incdir+dv
logic/alu_pkg.sv
logic/alu_op_decode.sv
logic/polar_lane.sv
logic/int_unit.sv
logic/result_select.sv
logic/alu_top.sv
dv/alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for a failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f alu_top.f --top-module alu_tb -o alu_sim \
    && ./obj_dir/alu_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "Simulation reported failure"; exit 1; } || exit 0
